//--- kdt_config.svh
// build-time sizes for the traversal unit
// KDT_MATH_LAT documents the fixed trav_math depth; changing it alone does not retime the pipe
`ifndef KDT_CONFIG_SVH
`define KDT_CONFIG_SVH

// identifier widths
`define KDT_RAYID_W   6
`define KDT_NODEID_W  16
`define KDT_TRI_W     20

// buffering
`define KDT_LEAF_DEPTH 4
`define KDT_TRAV_DEPTH 8   // also the credit limit for the rs channel

// trav_math input to output, in cycles
`define KDT_MATH_LAT  3

`endif

//--- kdt_pkg.sv
// all arithmetic values are signed Q16.16; node_type 2'b11 marks a leaf
// leaf_node_t is padded so both union members have the same width
`include "kdt_config.svh"

package kdt_pkg;

  typedef logic signed [31:0] fix_t;  // Q16.16
  typedef logic [`KDT_RAYID_W-1:0]  ray_id_t;
  typedef logic [`KDT_NODEID_W-1:0] node_id_t;
  typedef logic [`KDT_TRI_W-1:0]    ln_tri_t;

  typedef struct packed {
    logic [1:0] node_type;
    logic [1:0] axis;        // 0 x, 1 y, 2 z
    fix_t       split;
    node_id_t   right_id;    // low child is implicit, parent + 1
    logic       low_empty;
    logic       high_empty;
  } norm_node_t;

  localparam int LEAF_PAD_W = $bits(norm_node_t) - 2 - `KDT_TRI_W;

  typedef struct packed {
    logic [1:0]            node_type;
    ln_tri_t               ln_tri;
    logic [LEAF_PAD_W-1:0] rsvd;
  } leaf_node_t;

  typedef union packed {
    norm_node_t norm_node;
    leaf_node_t leaf_node;
  } tree_node_t;

  typedef struct packed {
    ray_id_t    ray_id;
    node_id_t   node_id;
    tree_node_t tree_node;
    logic       restnode_search;
    fix_t       t_max;
    fix_t       t_min;
  } tcache_to_trav_t;

  typedef struct packed {
    ray_id_t    ray_id;
    node_id_t   node_id;
    norm_node_t node;
    logic       restnode_search;
    fix_t       t_max;
    fix_t       t_min;
  } trav_to_rs_t;

  typedef struct packed {
    ray_id_t    ray_id;
    node_id_t   node_id;
    norm_node_t node;
    logic       restnode_search;
    fix_t       t_max;
    fix_t       t_min;
    fix_t [2:0] origin;
    fix_t [2:0] inv_dir;   // reciprocal supplied by the ray-store
  } rs_to_trav_t;

  typedef struct packed {
    ray_id_t  ray_id;
    logic     push_req;
    node_id_t push_node_id;
    fix_t     push_t_min;
    fix_t     push_t_max;
    logic     pop_req;
    logic     update_restnode_req;
    node_id_t rest_node_id;
  } trav_to_ss_t;

  typedef struct packed {
    ray_id_t  ray_id;
    node_id_t node_id;
    logic     restnode_search;
    fix_t     t_max;
    fix_t     t_min;
  } tarb_t;

  typedef struct packed {
    ray_id_t ray_id;
    ln_tri_t ln_tri;
  } leaf_info_t;

  typedef struct packed {
    ray_id_t ray_id;
    fix_t    t_max_leaf;
  } trav_to_list_t;

  typedef enum logic [1:0] {
    ONLY_LOW,
    ONLY_HIGH,
    LO_THEN_HI,
    HI_THEN_LO
  } trav_case_t;

  // carried alongside the math pipe
  typedef struct packed {
    ray_id_t  ray_id;
    node_id_t parent_id;
    node_id_t right_id;
    logic     low_empty;
    logic     high_empty;
    logic     restnode_search;
    fix_t     t_max;
    fix_t     t_min;
  } trav_sb_t;

  typedef struct packed {
    trav_sb_t   sb;
    fix_t       t_mid;
    trav_case_t tcase;
  } trav_res_t;

endpackage

//--- vs_buf.sv
// skid buffer: stall_us is a register output, one cycle latency, full throughput
`timescale 1ns/1ps

module vs_buf import kdt_pkg::*; #(
  parameter type T = fix_t
) (
  input  logic clk,
  input  logic arst_n,
  input  logic valid_us,
  input  T     data_us,
  output logic stall_us,
  output logic valid_ds,
  output T     data_ds,
  input  logic stall_ds
);

  logic out_valid;
  logic skid_valid;
  T     out_data;
  T     skid_data;
  logic out_free;

  assign out_free = ~out_valid | ~stall_ds;  // output slot empty or leaving

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid | valid_us;  // upstream is held off while skid is full
      skid_valid <= 1'b0;
    end else if (valid_us && !skid_valid) begin
      skid_valid <= 1'b1;                    // catch the item that missed the stall
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data <= skid_valid ? skid_data : data_us;
    end
    if (!out_free && valid_us && !skid_valid) begin
      skid_data <= data_us;
    end
  end

  assign stall_us = skid_valid;
  assign valid_ds = out_valid;
  assign data_ds  = out_data;

endmodule

//--- sync_fifo.sv
// first-word fall-through FIFO; callers must not write when full or read when empty
`timescale 1ns/1ps

module sync_fifo import kdt_pkg::*; #(
  parameter type T     = fix_t,
  parameter int  DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       we,
  input  logic                       re,
  input  T                           data_in,
  output T                           data_out,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;

  assign full     = (count == CW'(DEPTH));
  assign empty    = (count == '0);
  assign data_out = mem[rd_ptr];  // head visible without a read

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (we) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (re) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(we) - CW'(re);
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_ptr] <= data_in;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) !(we && full))
    else $error("write into full FIFO");

  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) !(re && empty))
    else $error("read from empty FIFO");

endmodule

//--- trav_math.sv
// fixed 3-cycle pipe, no stall; SB must carry t_max and t_min fields
// t_mid saturates to the Q16.16 range, axis 3 is treated as z
`timescale 1ns/1ps

module trav_math import kdt_pkg::*; #(
  parameter type SB = trav_sb_t
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       in_valid,
  input  fix_t [2:0] origin,
  input  fix_t [2:0] inv_dir,
  input  logic [1:0] axis,
  input  fix_t       split,
  input  SB          sb_in,
  output logic       out_valid,
  output fix_t       t_mid,
  output trav_case_t tcase,
  output SB          sb_out
);

  localparam fix_t FIX_MAX = 32'sh7fff_ffff;
  localparam fix_t FIX_MIN = 32'sh8000_0000;

  logic [1:0] ax;
  fix_t       org_c;
  fix_t       inv_c;

  logic               s1_valid;
  logic signed [32:0] s1_diff;   // one extra bit so split - origin cannot wrap
  fix_t               s1_inv;
  logic               s1_near_low;
  SB                  s1_sb;

  logic signed [64:0] prod;
  logic signed [48:0] scaled;
  fix_t               rnd;

  logic       s2_valid;
  fix_t       s2_tmid;
  logic       s2_near_low;
  SB          s2_sb;
  trav_case_t cls;

  assign ax    = (axis == 2'd3) ? 2'd2 : axis;
  assign org_c = origin[ax];
  assign inv_c = inv_dir[ax];

  // stage 1, subtract and pick the near side
  always_ff @(posedge clk) begin
    s1_diff     <= 33'(split) - 33'(org_c);
    s1_inv      <= inv_c;
    s1_near_low <= (org_c < split) || ((org_c == split) && !inv_c[31]);
    s1_sb       <= sb_in;
  end

  // stage 2, Q16.16 product with round half up
  assign prod   = s1_diff * s1_inv;
  assign scaled = 49'((prod + 65'sd32768) >>> 16);

  always_comb begin
    if (scaled > FIX_MAX) begin
      rnd = FIX_MAX;
    end else if (scaled < FIX_MIN) begin
      rnd = FIX_MIN;
    end else begin
      rnd = fix_t'(scaled);
    end
  end

  always_ff @(posedge clk) begin
    s2_tmid     <= rnd;
    s2_near_low <= s1_near_low;
    s2_sb       <= s1_sb;
  end

  // stage 3, classify against the ray interval
  always_comb begin
    if (s2_tmid < 0 || s2_tmid >= s2_sb.t_max) begin
      cls = s2_near_low ? ONLY_LOW : ONLY_HIGH;   // plane behind or past the segment
    end else if (s2_tmid <= s2_sb.t_min) begin
      cls = s2_near_low ? ONLY_HIGH : ONLY_LOW;   // far side only
    end else begin
      cls = s2_near_low ? LO_THEN_HI : HI_THEN_LO;
    end
  end

  always_ff @(posedge clk) begin
    t_mid  <= s2_tmid;
    tcase  <= cls;
    sb_out <= s2_sb;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  // rounding and saturation never flip the sign of the product
  a_tmid_sign: assert property (@(posedge clk) disable iff (!arst_n)
    s1_valid |-> !((prod > 0 && rnd < 0) || (prod < 0 && rnd > 0)))
    else $error("t_mid sign differs from the product sign");

endmodule

//--- trav_unit.sv
// kd-tree traversal stage; every channel is valid/data with a stall from the receiver
// rs channel is credit limited to KDT_TRAV_DEPTH items in math pipe plus decision FIFO
`timescale 1ns/1ps
`include "kdt_config.svh"

module trav_unit import kdt_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,

  input  logic            tcache_to_trav_valid,
  input  tcache_to_trav_t tcache_to_trav_data,
  output logic            tcache_to_trav_stall,

  output logic            trav_to_rs_valid,
  output trav_to_rs_t     trav_to_rs_data,
  input  logic            trav_to_rs_stall,

  input  logic            rs_to_trav_valid,
  input  rs_to_trav_t     rs_to_trav_data,
  output logic            rs_to_trav_stall,

  output logic            trav_to_ss_valid,   // push, pop and restnode update share it
  output trav_to_ss_t     trav_to_ss_data,
  input  logic            trav_to_ss_stall,

  output logic            trav_to_tarb_valid,
  output tarb_t           trav_to_tarb_data,
  input  logic            trav_to_tarb_stall,

  output logic            trav_to_larb_valid,
  output leaf_info_t      trav_to_larb_data,
  input  logic            trav_to_larb_stall,

  output logic            trav_to_list_valid,
  output trav_to_list_t   trav_to_list_data,
  input  logic            trav_to_list_stall
);

  localparam int TCW = $clog2(`KDT_TRAV_DEPTH + 1);
  localparam int PW  = $clog2(`KDT_MATH_LAT + 1);

  typedef struct packed {
    leaf_info_t info;
    fix_t       t_max;
  } leaf_ent_t;

  logic            tc_valid;
  tcache_to_trav_t tc_data;
  logic            tc_stall;
  logic            is_leaf;
  leaf_ent_t       leaf_in, leaf_out;
  logic            leaf_we, leaf_re, leaf_full, leaf_empty;
  logic            larb_free, list_free;

  vs_buf #(.T(tcache_to_trav_t)) u_tc_buf (
    .clk, .arst_n,
    .valid_us (tcache_to_trav_valid),
    .data_us  (tcache_to_trav_data),
    .stall_us (tcache_to_trav_stall),
    .valid_ds (tc_valid),
    .data_ds  (tc_data),
    .stall_ds (tc_stall)
  );

  assign is_leaf  = (tc_data.tree_node.leaf_node.node_type == 2'b11);
  assign tc_stall = tc_valid & (is_leaf ? leaf_full : trav_to_rs_stall);

  // interior nodes go straight to the ray-store
  assign trav_to_rs_valid = tc_valid & ~is_leaf;
  always_comb begin
    trav_to_rs_data.ray_id          = tc_data.ray_id;
    trav_to_rs_data.node_id         = tc_data.node_id;
    trav_to_rs_data.node            = tc_data.tree_node.norm_node;
    trav_to_rs_data.restnode_search = tc_data.restnode_search;
    trav_to_rs_data.t_max           = tc_data.t_max;
    trav_to_rs_data.t_min           = tc_data.t_min;
  end

  // leaf route
  assign leaf_in.info.ray_id = tc_data.ray_id;
  assign leaf_in.info.ln_tri = tc_data.tree_node.leaf_node.ln_tri;
  assign leaf_in.t_max       = tc_data.t_max;
  assign leaf_we             = tc_valid & is_leaf & ~leaf_full;

  sync_fifo #(.T(leaf_ent_t), .DEPTH(`KDT_LEAF_DEPTH)) u_leaf_fifo (
    .clk, .arst_n,
    .we       (leaf_we),
    .re       (leaf_re),
    .data_in  (leaf_in),
    .data_out (leaf_out),
    .full     (leaf_full),
    .empty    (leaf_empty),
    .count    ()
  );

  assign larb_free = ~trav_to_larb_valid | ~trav_to_larb_stall;
  assign list_free = ~trav_to_list_valid | ~trav_to_list_stall;
  assign leaf_re   = ~leaf_empty & larb_free & list_free;  // both load together

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trav_to_larb_valid <= 1'b0;
      trav_to_list_valid <= 1'b0;
    end else begin
      if (leaf_re) trav_to_larb_valid <= 1'b1;
      else if (!trav_to_larb_stall) trav_to_larb_valid <= 1'b0;
      if (leaf_re) trav_to_list_valid <= 1'b1;
      else if (!trav_to_list_stall) trav_to_list_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (leaf_re) begin
      trav_to_larb_data            <= leaf_out.info;
      trav_to_list_data.ray_id     <= leaf_out.info.ray_id;
      trav_to_list_data.t_max_leaf <= leaf_out.t_max;
    end
  end

  // interior route, math pipe then decision FIFO
  logic           rs_accept;
  trav_sb_t       sb_in;
  trav_res_t      math_res, hd;
  logic           math_valid;
  logic [PW-1:0]  pipe_cnt;   // items inside trav_math
  logic [TCW-1:0] trav_cnt;
  logic [TCW:0]   credit;
  logic           trav_re, trav_full, trav_empty;

  assign credit           = (TCW + 1)'(pipe_cnt) + (TCW + 1)'(trav_cnt);
  assign rs_to_trav_stall = (credit >= (TCW + 1)'(`KDT_TRAV_DEPTH));
  assign rs_accept        = rs_to_trav_valid & ~rs_to_trav_stall;

  always_comb begin
    sb_in.ray_id          = rs_to_trav_data.ray_id;
    sb_in.parent_id       = rs_to_trav_data.node_id;
    sb_in.right_id        = rs_to_trav_data.node.right_id;
    sb_in.low_empty       = rs_to_trav_data.node.low_empty;
    sb_in.high_empty      = rs_to_trav_data.node.high_empty;
    sb_in.restnode_search = rs_to_trav_data.restnode_search;
    sb_in.t_max           = rs_to_trav_data.t_max;
    sb_in.t_min           = rs_to_trav_data.t_min;
  end

  trav_math #(.SB(trav_sb_t)) u_math (
    .clk, .arst_n,
    .in_valid  (rs_accept),
    .origin    (rs_to_trav_data.origin),
    .inv_dir   (rs_to_trav_data.inv_dir),
    .axis      (rs_to_trav_data.node.axis),
    .split     (rs_to_trav_data.node.split),
    .sb_in     (sb_in),
    .out_valid (math_valid),
    .t_mid     (math_res.t_mid),
    .tcase     (math_res.tcase),
    .sb_out    (math_res.sb)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) pipe_cnt <= '0;
    else pipe_cnt <= pipe_cnt + PW'(rs_accept) - PW'(math_valid);
  end

  sync_fifo #(.T(trav_res_t), .DEPTH(`KDT_TRAV_DEPTH)) u_trav_fifo (
    .clk, .arst_n,
    .we       (math_valid),
    .re       (trav_re),
    .data_in  (math_res),
    .data_out (hd),
    .full     (trav_full),
    .empty    (trav_empty),
    .count    (trav_cnt)
  );

  // decision, for single-child cases the child is the near one
  node_id_t    low_id, near_id, far_id;
  logic        near_low, near_empty, far_empty, both, push, pop;
  logic        need_ss, need_tarb, ss_free, tarb_free;
  trav_to_ss_t ss_n;
  tarb_t       tarb_n;

  assign low_id     = hd.sb.parent_id + 1'b1;
  assign near_low   = (hd.tcase == ONLY_LOW) || (hd.tcase == LO_THEN_HI);
  assign both       = (hd.tcase == LO_THEN_HI) || (hd.tcase == HI_THEN_LO);
  assign near_id    = near_low ? low_id : hd.sb.right_id;
  assign far_id     = near_low ? hd.sb.right_id : low_id;
  assign near_empty = near_low ? hd.sb.low_empty : hd.sb.high_empty;
  assign far_empty  = near_low ? hd.sb.high_empty : hd.sb.low_empty;
  assign push       = both & ~near_empty & ~far_empty;
  assign pop        = near_empty & (~both | far_empty);
  assign need_ss    = push | pop;
  assign need_tarb  = ~pop;

  always_comb begin
    ss_n.ray_id              = hd.sb.ray_id;
    ss_n.push_req            = push;
    ss_n.push_node_id        = far_id;
    ss_n.push_t_min          = hd.t_mid;
    ss_n.push_t_max          = hd.sb.t_max;
    ss_n.pop_req             = pop;
    ss_n.update_restnode_req = hd.sb.restnode_search & push;
    ss_n.rest_node_id        = hd.sb.parent_id;

    tarb_n.ray_id          = hd.sb.ray_id;
    tarb_n.restnode_search = hd.sb.restnode_search & ~push;
    tarb_n.node_id         = (!both || !near_empty) ? near_id : far_id;
    if (!both) begin
      tarb_n.t_min = hd.sb.t_min;   // interval unchanged
      tarb_n.t_max = hd.sb.t_max;
    end else if (!near_empty) begin
      tarb_n.t_min = hd.sb.t_min;
      tarb_n.t_max = hd.t_mid;
    end else begin
      tarb_n.t_min = hd.t_mid;
      tarb_n.t_max = hd.sb.t_max;
    end
  end

  assign ss_free   = ~trav_to_ss_valid | ~trav_to_ss_stall;
  assign tarb_free = ~trav_to_tarb_valid | ~trav_to_tarb_stall;
  assign trav_re   = ~trav_empty & (~need_ss | ss_free) & (~need_tarb | tarb_free);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trav_to_ss_valid   <= 1'b0;
      trav_to_tarb_valid <= 1'b0;
    end else begin
      if (trav_re && need_ss) trav_to_ss_valid <= 1'b1;
      else if (!trav_to_ss_stall) trav_to_ss_valid <= 1'b0;
      if (trav_re && need_tarb) trav_to_tarb_valid <= 1'b1;
      else if (!trav_to_tarb_stall) trav_to_tarb_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (trav_re && need_ss) trav_to_ss_data <= ss_n;
    if (trav_re && need_tarb) trav_to_tarb_data <= tarb_n;
  end

  // credit bookkeeping must track the real math latency
  a_math_latency: assert property (@(posedge clk) disable iff (!arst_n)
    rs_accept |-> ##(`KDT_MATH_LAT) math_valid)
    else $error("trav_math latency differs from KDT_MATH_LAT");

  a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
    credit <= (TCW + 1)'(`KDT_TRAV_DEPTH) && !(math_valid && trav_full && !trav_re))
    else $error("rs credit exceeded");

endmodule

//--- tb_trav.sv
// random traffic on every channel of trav_unit, checked against a behavioral model
// cache, ray-store, short stack, arbiters and hit list are all modeled here
`timescale 1ns/1ps
`include "kdt_config.svh"

module tb_trav import kdt_pkg::*; ();

  localparam int N_TC = 300;   // cache items, leaves and interior nodes mixed
  localparam int N_RS = 200;
  localparam int N_RN = 80;    // ray-store items with restnode_search set
  localparam int N_BP = 24;
  localparam int WATCHDOG_CYCLES = 200 * (N_TC + N_RS + N_RN + N_BP);
  localparam int FIX_ONE = 1 << 16;

  logic            clk = 1'b0;
  logic            arst_n;
  logic            tcache_to_trav_valid;
  tcache_to_trav_t tcache_to_trav_data;
  logic            tcache_to_trav_stall;
  logic            trav_to_rs_valid;
  trav_to_rs_t     trav_to_rs_data;
  logic            trav_to_rs_stall;
  logic            rs_to_trav_valid;
  rs_to_trav_t     rs_to_trav_data;
  logic            rs_to_trav_stall;
  logic            trav_to_ss_valid;
  trav_to_ss_t     trav_to_ss_data;
  logic            trav_to_ss_stall;
  logic            trav_to_tarb_valid;
  tarb_t           trav_to_tarb_data;
  logic            trav_to_tarb_stall;
  logic            trav_to_larb_valid;
  leaf_info_t      trav_to_larb_data;
  logic            trav_to_larb_stall;
  logic            trav_to_list_valid;
  trav_to_list_t   trav_to_list_data;
  logic            trav_to_list_stall;

  integer seed = 32'hbe8d;

  tcache_to_trav_t tc_q[$];     // stimulus not yet offered
  rs_to_trav_t     rs_q[$];
  trav_to_rs_t     exp_rs[$];   // expected items per output channel
  leaf_info_t      exp_larb[$];
  trav_to_list_t   exp_list[$];
  trav_to_ss_t     exp_ss[$];
  tarb_t           exp_tarb[$];
  trav_to_ss_t     ss_e;

  logic  tc_took = 1'b0;
  logic  rs_took = 1'b0;
  logic  hold_out = 1'b0;       // ss and tarb receivers refuse everything
  logic  saw_credit_stall;
  int    held_accepts;
  string cur_test;
  int    test_errs;
  int    total_errs = 0;
  int    n_checks = 0;
  int    n_tests = 0;
  int    n_bad_tests = 0;

  trav_unit u_dut (
    .clk, .arst_n,
    .tcache_to_trav_valid, .tcache_to_trav_data, .tcache_to_trav_stall,
    .trav_to_rs_valid, .trav_to_rs_data, .trav_to_rs_stall,
    .rs_to_trav_valid, .rs_to_trav_data, .rs_to_trav_stall,
    .trav_to_ss_valid, .trav_to_ss_data, .trav_to_ss_stall,
    .trav_to_tarb_valid, .trav_to_tarb_data, .trav_to_tarb_stall,
    .trav_to_larb_valid, .trav_to_larb_data, .trav_to_larb_stall,
    .trav_to_list_valid, .trav_to_list_data, .trav_to_list_stall
  );

  always #10 clk = ~clk;

  function automatic int unsigned urand(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic fix_t rand_fix(int unsigned range);  // in [-range, range)
    return fix_t'(int'(urand(2 * range)) - int'(range));
  endfunction

  function automatic norm_node_t make_norm_node();
    norm_node_t nn;
    nn.node_type  = 2'(urand(3));
    nn.axis       = 2'(urand(3));
    nn.split      = rand_fix(16 * FIX_ONE);
    nn.right_id   = node_id_t'(urand(65536));
    nn.low_empty  = urand(4) == 0;
    nn.high_empty = urand(4) == 0;
    return nn;
  endfunction

  function automatic tcache_to_trav_t make_tc_item();
    tcache_to_trav_t it;
    leaf_node_t      lf;
    it.ray_id          = ray_id_t'(urand(64));
    it.node_id         = node_id_t'(urand(65536));
    it.restnode_search = urand(2) == 1;
    it.t_min           = fix_t'(urand(32 * FIX_ONE));
    it.t_max           = it.t_min + fix_t'(FIX_ONE + urand(64 * FIX_ONE));
    if (urand(10) < 4) begin
      lf.node_type = 2'b11;
      lf.ln_tri    = ln_tri_t'(urand(1 << `KDT_TRI_W));
      lf.rsvd      = $random(seed);   // padding must not matter
      it.tree_node.leaf_node = lf;
    end else begin
      it.tree_node.norm_node = make_norm_node();
    end
    return it;
  endfunction

  function automatic rs_to_trav_t make_rs_item(logic force_rn);
    rs_to_trav_t it;
    int          ax;
    it.ray_id          = ray_id_t'(urand(64));
    it.node_id         = node_id_t'(urand(65536));
    it.node            = make_norm_node();
    it.restnode_search = force_rn | (urand(2) == 1);
    it.t_min           = fix_t'(urand(32 * FIX_ONE));
    it.t_max           = it.t_min + fix_t'(FIX_ONE + urand(64 * FIX_ONE));
    for (int i = 0; i < 3; i++) begin
      it.origin[i]  = rand_fix(16 * FIX_ONE);
      it.inv_dir[i] = rand_fix(4 * FIX_ONE);
    end
    ax = it.node.axis;
    if (urand(8) == 0) it.origin[ax] = it.node.split;  // ray starts on the plane
    if (urand(16) == 0) it.inv_dir[ax] = '0;
    return it;
  endfunction

  // Q16.16 product, rounded half up, saturated to one word
  function automatic fix_t qmul(longint a, longint b);
    longint q;
    q = (a * b + 64'sd32768) >>> 16;
    if (q > 64'sd2147483647) return 32'sh7fff_ffff;
    if (q < -64'sd2147483648) return 32'sh8000_0000;
    return fix_t'(q);
  endfunction

  task automatic model_tcache(input tcache_to_trav_t t);
    leaf_info_t    li;
    trav_to_list_t ls;
    trav_to_rs_t   rq;
    if (t.tree_node.leaf_node.node_type == 2'b11) begin
      li.ray_id     = t.ray_id;
      li.ln_tri     = t.tree_node.leaf_node.ln_tri;
      ls.ray_id     = t.ray_id;
      ls.t_max_leaf = t.t_max;
      exp_larb.push_back(li);
      exp_list.push_back(ls);
    end else begin
      rq.ray_id          = t.ray_id;
      rq.node_id         = t.node_id;
      rq.node            = t.tree_node.norm_node;
      rq.restnode_search = t.restnode_search;
      rq.t_max           = t.t_max;
      rq.t_min           = t.t_min;
      exp_rs.push_back(rq);
    end
  endtask

  task automatic model_rs(input rs_to_trav_t r);
    int          ax;
    fix_t        org, inv, split, tmid;
    logic        near_low, two, child_low, near_e, far_e;
    node_id_t    low_id, near_id, far_id;
    trav_to_ss_t ss;
    tarb_t       tb;
    ax    = r.node.axis;
    org   = r.origin[ax];
    inv   = r.inv_dir[ax];
    split = r.node.split;
    tmid  = qmul(longint'(split) - longint'(org), longint'(inv));
    near_low  = (org < split) || (org == split && inv >= 0);
    two       = 1'b0;
    child_low = near_low;
    if (tmid < 0 || tmid >= r.t_max) child_low = near_low;
    else if (tmid <= r.t_min) child_low = !near_low;
    else two = 1'b1;
    low_id  = r.node_id + 16'd1;
    near_id = near_low ? low_id : r.node.right_id;
    far_id  = near_low ? r.node.right_id : low_id;
    near_e  = near_low ? r.node.low_empty : r.node.high_empty;
    far_e   = near_low ? r.node.high_empty : r.node.low_empty;
    ss = '0;
    ss.ray_id       = r.ray_id;
    ss.rest_node_id = r.node_id;
    tb.ray_id          = r.ray_id;
    tb.node_id         = near_id;
    tb.restnode_search = r.restnode_search;
    tb.t_min           = r.t_min;
    tb.t_max           = r.t_max;
    if (!two) begin
      if (child_low ? r.node.low_empty : r.node.high_empty) ss.pop_req = 1'b1;
      else tb.node_id = child_low ? low_id : r.node.right_id;
    end else if (!near_e && !far_e) begin
      ss.push_req            = 1'b1;
      ss.push_node_id        = far_id;
      ss.push_t_min          = tmid;
      ss.push_t_max          = r.t_max;
      ss.update_restnode_req = r.restnode_search;
      tb.t_max               = tmid;
      tb.restnode_search     = 1'b0;
    end else if (near_e && far_e) begin
      ss.pop_req = 1'b1;
    end else if (!near_e) begin
      tb.t_max = tmid;
    end else begin
      tb.node_id = far_id;
      tb.t_min   = tmid;
    end
    if (ss.push_req || ss.pop_req) exp_ss.push_back(ss);
    if (!ss.pop_req) exp_tarb.push_back(tb);
  endtask

  // push fields mean nothing without a push
  function automatic trav_to_ss_t ss_view(trav_to_ss_t s, logic keep_push);
    if (!keep_push) begin
      s.push_node_id = '0;
      s.push_t_min   = '0;
      s.push_t_max   = '0;
    end
    return s;
  endfunction

  task automatic check_val(input string chan, input logic [255:0] exp, input logic [255:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("Fail %s %s: expected %0h actual %0h", cur_test, chan, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error in %s: %s", cur_test, msg);
    test_errs++;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    n_tests++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s ok", cur_test);
    end else begin
      n_bad_tests++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic wait_idle();
    do @(posedge clk);
    while (tc_q.size() + rs_q.size() + exp_rs.size() + exp_larb.size() + exp_list.size()
           + exp_ss.size() + exp_tarb.size() != 0 || tcache_to_trav_valid || rs_to_trav_valid);
    repeat (20) @(posedge clk);  // room for any stray output
  endtask

  // accepts and output checks, all at the rising edge
  always @(posedge clk) begin
    tc_took = arst_n && tcache_to_trav_valid && !tcache_to_trav_stall;
    rs_took = arst_n && rs_to_trav_valid && !rs_to_trav_stall;
    if (tc_took) model_tcache(tcache_to_trav_data);
    if (rs_took) model_rs(rs_to_trav_data);
    if (hold_out && rs_took) held_accepts++;
    if (hold_out && rs_to_trav_stall) saw_credit_stall = 1'b1;
    if (arst_n && trav_to_rs_valid && !trav_to_rs_stall) begin
      if (exp_rs.size() == 0) report_error("item on trav_to_rs with none expected");
      else check_val("trav_to_rs", exp_rs.pop_front(), trav_to_rs_data);
    end
    if (arst_n && trav_to_larb_valid && !trav_to_larb_stall) begin
      if (exp_larb.size() == 0) report_error("item on trav_to_larb with none expected");
      else check_val("trav_to_larb", exp_larb.pop_front(), trav_to_larb_data);
    end
    if (arst_n && trav_to_list_valid && !trav_to_list_stall) begin
      if (exp_list.size() == 0) report_error("item on trav_to_list with none expected");
      else check_val("trav_to_list", exp_list.pop_front(), trav_to_list_data);
    end
    if (arst_n && trav_to_ss_valid && !trav_to_ss_stall) begin
      if (exp_ss.size() == 0) begin
        report_error("item on trav_to_ss with none expected");
      end else begin
        ss_e = exp_ss.pop_front();
        check_val("trav_to_ss", ss_view(ss_e, ss_e.push_req),
                  ss_view(trav_to_ss_data, ss_e.push_req));
      end
    end
    if (arst_n && trav_to_tarb_valid && !trav_to_tarb_stall) begin
      if (exp_tarb.size() == 0) report_error("item on trav_to_tarb with none expected");
      else check_val("trav_to_tarb", exp_tarb.pop_front(), trav_to_tarb_data);
    end
  end

  // all DUT inputs change on the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      trav_to_rs_stall   = urand(10) < 3;
      trav_to_larb_stall = urand(10) < 3;
      trav_to_list_stall = urand(10) < 3;
      trav_to_ss_stall   = (urand(10) < 3) || hold_out;
      trav_to_tarb_stall = (urand(10) < 3) || hold_out;
      if (!tcache_to_trav_valid || tc_took) begin
        if (tc_q.size() > 0 && urand(4) != 0) begin
          tcache_to_trav_data  = tc_q.pop_front();
          tcache_to_trav_valid = 1'b1;
        end else begin
          tcache_to_trav_valid = 1'b0;
        end
      end
      if (!rs_to_trav_valid || rs_took) begin
        if (rs_q.size() > 0 && urand(4) != 0) begin
          rs_to_trav_data  = rs_q.pop_front();
          rs_to_trav_valid = 1'b1;
        end else begin
          rs_to_trav_valid = 1'b0;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run still going after %0d cycles, outputs stuck", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int cyc;
    arst_n               = 1'b0;
    tcache_to_trav_valid = 1'b0;
    tcache_to_trav_data  = '0;
    rs_to_trav_valid     = 1'b0;
    rs_to_trav_data      = '0;
    trav_to_rs_stall     = 1'b0;
    trav_to_ss_stall     = 1'b0;
    trav_to_tarb_stall   = 1'b0;
    trav_to_larb_stall   = 1'b0;
    trav_to_list_stall   = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    start_test("reset");
    @(negedge clk);
    check_val("tcache_to_trav_stall", 0, tcache_to_trav_stall);
    check_val("rs_to_trav_stall", 0, rs_to_trav_stall);
    check_val("trav_to_rs_valid", 0, trav_to_rs_valid);
    check_val("trav_to_ss_valid", 0, trav_to_ss_valid);
    check_val("trav_to_tarb_valid", 0, trav_to_tarb_valid);
    check_val("trav_to_larb_valid", 0, trav_to_larb_valid);
    check_val("trav_to_list_valid", 0, trav_to_list_valid);
    end_test();

    start_test("cache_routing");
    for (int i = 0; i < N_TC; i++) tc_q.push_back(make_tc_item());
    wait_idle();
    end_test();

    start_test("decision");
    for (int i = 0; i < N_RS; i++) rs_q.push_back(make_rs_item(1'b0));
    wait_idle();
    end_test();

    start_test("restnode");
    for (int i = 0; i < N_RN; i++) rs_q.push_back(make_rs_item(1'b1));
    wait_idle();
    end_test();

    start_test("backpressure");
    saw_credit_stall = 1'b0;
    held_accepts     = 0;
    hold_out         = 1'b1;
    for (int i = 0; i < N_BP; i++) rs_q.push_back(make_rs_item(1'b0));
    cyc = 0;
    while (!saw_credit_stall && cyc < 400) begin
      @(posedge clk);
      cyc++;
    end
    if (!saw_credit_stall) report_error("rs_to_trav_stall never rose with ss and tarb held");
    repeat (50) @(posedge clk);
    // credit window plus one item in each output register
    if (held_accepts > `KDT_TRAV_DEPTH + 2) begin
      report_error($sformatf("%0d rs items accepted while outputs were held", held_accepts));
    end
    hold_out = 1'b0;
    wait_idle();
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_bad_tests, n_checks, total_errs);
    if (total_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+.
kdt_pkg.sv
vs_buf.sv
sync_fifo.sv
trav_math.sv
trav_unit.sv
tb_trav.sv

//--- Makefile
# Verilator build and run of the traversal unit testbench
TOP := tb_trav

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f files.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
